// File: rtl/uart_pkg.sv
package uart_pkg;

    // Serial frame is 8N1, LSB first
    localparam int data_bits = 8;

    // Bit period in clock cycles is held in a register of this width
    localparam int div_width = 16;

    localparam int fifo_depth = 4;

    // Entry stored by the receiver for every frame it sees
    typedef struct packed {
        logic [data_bits-1:0] data;
        logic                 frame_err;
    } rx_entry_t;

endpackage

// File: rtl/uart_regs_pkg.sv
package uart_regs_pkg;

    localparam int addr_width = 4;

    // Register offsets on the APB bus
    localparam logic [addr_width-1:0] addr_data   = 4'h0;
    localparam logic [addr_width-1:0] addr_status = 4'h4;
    localparam logic [addr_width-1:0] addr_ctrl   = 4'h8;
    localparam logic [addr_width-1:0] addr_div    = 4'hC;

    localparam int ctrl_tx_en_bit = 0;
    localparam int ctrl_rx_en_bit = 1;

    localparam int status_tx_full_bit  = 0;
    localparam int status_tx_empty_bit = 1;
    localparam int status_rx_empty_bit = 2;
    localparam int status_rx_full_bit  = 3;
    localparam int status_tx_busy_bit  = 4;
    localparam int status_overrun_bit  = 5;

    localparam int div_reset = 16;
    localparam int div_min   = 4;

endpackage

// File: rtl/fifo_if.sv
interface fifo_if #(
    parameter type payload_t = logic [7:0]
);

    logic     push;
    payload_t wdata;
    logic     full;
    logic     pop;
    payload_t rdata;
    logic     empty;

    // Producer and consumer views
    modport writer (output push, output wdata, input full, input empty);
    modport reader (output pop, input rdata, input empty, input full);

    // The FIFO itself sits on the other side of both views
    modport wr_target (input push, input wdata, output full);
    modport rd_target (input pop, output rdata, output empty);

endinterface

// File: rtl/uart_fifo.sv
module uart_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic      clk,
    input  logic      rst,
    fifo_if.wr_target wr,
    fifo_if.rd_target rd
);

    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;

    payload_t             mem [depth];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width:0]   count;
    logic                 do_push;
    logic                 do_pop;

    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        return (ptr == ptr_width'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign wr.full  = (count == (ptr_width + 1)'(depth));
    assign rd.empty = (count == '0);
    assign rd.rdata = mem[rd_ptr];

    // A push into a full FIFO is lost even if a pop happens in the same cycle
    assign do_push = wr.push && !wr.full;
    assign do_pop  = rd.pop && !rd.empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: rtl/uart_regs.sv
module uart_regs
    import uart_pkg::*;
    import uart_regs_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [addr_width-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    fifo_if.writer                tx_wr,
    fifo_if.reader                rx_rd,
    output logic                  tx_en,
    output logic                  rx_en,
    output logic [div_width-1:0]  div,
    input  logic                  tx_busy,
    input  logic                  push_drop
);

    logic        access;
    logic        mapped;
    logic        data_rd;
    logic        wr_fire;
    logic        rd_wait;
    logic        overrun;
    logic [9:0]  rd_entry;
    logic [31:0] status_word;
    logic [31:0] reg_rdata;

    assign access = psel && penable;
    assign mapped = (paddr == addr_data) || (paddr == addr_status) ||
                    (paddr == addr_ctrl) || (paddr == addr_div);

    // Data reads take one wait state so the popped entry can be registered
    assign data_rd = access && !pwrite && (paddr == addr_data);
    assign pready  = access && (!data_rd || rd_wait);
    assign pslverr = pready && !mapped;
    assign wr_fire = pready && pwrite && mapped;

    assign tx_wr.push  = wr_fire && (paddr == addr_data) && !tx_wr.full;
    assign tx_wr.wdata = pwdata[data_bits-1:0];
    assign rx_rd.pop   = data_rd && !rd_wait && !rx_rd.empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_wait <= 1'b0;
            tx_en   <= 1'b0;
            rx_en   <= 1'b0;
            div     <= div_width'(div_reset);
            overrun <= 1'b0;
        end else begin
            rd_wait <= data_rd && !rd_wait;
            if (wr_fire && (paddr == addr_ctrl)) begin
                tx_en <= pwdata[ctrl_tx_en_bit];
                rx_en <= pwdata[ctrl_rx_en_bit];
            end
            if (wr_fire && (paddr == addr_div)) begin
                if (pwdata[div_width-1:0] < div_width'(div_min)) begin
                    div <= div_width'(div_min);
                end else begin
                    div <= pwdata[div_width-1:0];
                end
            end
            // A new drop wins over a clear in the same cycle
            if (push_drop) begin
                overrun <= 1'b1;
            end else if (wr_fire && (paddr == addr_status) && pwdata[status_overrun_bit]) begin
                overrun <= 1'b0;
            end
        end
    end

    // Layout is valid in bit 9, frame_err in bit 8, data below
    always_ff @(posedge clk) begin
        if (data_rd && !rd_wait) begin
            if (rx_rd.empty) begin
                rd_entry <= '0;
            end else begin
                rd_entry <= {1'b1, rx_rd.rdata.frame_err, rx_rd.rdata.data};
            end
        end
    end

    always_comb begin
        status_word = '0;
        status_word[status_tx_full_bit]  = tx_wr.full;
        status_word[status_tx_empty_bit] = tx_wr.empty;
        status_word[status_rx_empty_bit] = rx_rd.empty;
        status_word[status_rx_full_bit]  = rx_rd.full;
        status_word[status_tx_busy_bit]  = tx_busy;
        status_word[status_overrun_bit]  = overrun;
    end

    always_comb begin
        reg_rdata = '0;
        case (paddr)
            addr_data:   reg_rdata[9:0] = rd_entry;
            addr_status: reg_rdata = status_word;
            addr_ctrl: begin
                reg_rdata[ctrl_tx_en_bit] = tx_en;
                reg_rdata[ctrl_rx_en_bit] = rx_en;
            end
            addr_div:    reg_rdata[div_width-1:0] = div;
            default:     reg_rdata = '0;
        endcase
    end

    // Held at zero during the wait state and outside reads
    assign prdata = (pready && !pwrite) ? reg_rdata : '0;

endmodule

// File: rtl/uart_tx.sv
module uart_tx
    import uart_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tx_en,
    input  logic [div_width-1:0] div,
    fifo_if.reader               q,
    output logic                 busy,
    output logic                 txd
);

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

    state_t               state_d, state_q;
    logic [div_width-1:0] ctr_d, ctr_q;
    logic [2:0]           bit_ctr_d, bit_ctr_q;
    logic [data_bits-1:0] data_d, data_q;
    logic                 txd_d, txd_q;
    logic                 bit_done;

    assign txd      = txd_q;
    assign bit_done = (ctr_q == div - 1'b1);

    // Disabled transmitter reports busy so software sees it is held
    assign busy = (state_q != st_idle) || !tx_en || q.pop;

    always_comb begin
        state_d   = state_q;
        ctr_d     = ctr_q + 1'b1;
        bit_ctr_d = bit_ctr_q;
        data_d    = data_q;
        txd_d     = txd_q;
        q.pop     = 1'b0;
        case (state_q)
            st_idle: begin
                ctr_d     = '0;
                bit_ctr_d = '0;
                txd_d     = 1'b1;
                if (tx_en && !q.empty) begin
                    q.pop   = 1'b1;
                    data_d  = q.rdata;
                    txd_d   = 1'b0;
                    state_d = st_start;
                end
            end
            st_start: begin
                if (bit_done) begin
                    ctr_d   = '0;
                    txd_d   = data_q[0];
                    state_d = st_data;
                end
            end
            st_data: begin
                if (bit_done) begin
                    ctr_d = '0;
                    if (bit_ctr_q == 3'(data_bits - 1)) begin
                        txd_d   = 1'b1;
                        state_d = st_stop;
                    end else begin
                        bit_ctr_d = bit_ctr_q + 1'b1;
                        txd_d     = data_q[bit_ctr_q + 1'b1];
                    end
                end
            end
            st_stop: begin
                if (bit_done) begin
                    ctr_d   = '0;
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
            txd_q   <= 1'b1;
        end else begin
            state_q <= state_d;
            txd_q   <= txd_d;
        end
        ctr_q     <= ctr_d;
        bit_ctr_q <= bit_ctr_d;
        data_q    <= data_d;
    end

endmodule

// File: rtl/uart_rx.sv
module uart_rx
    import uart_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rx_en,
    input  logic [div_width-1:0] div,
    input  logic                 rxd,
    fifo_if.writer               q,
    output logic                 push_drop
);

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

    state_t               state_d, state_q;
    logic                 rxd_meta;
    logic                 rxd_sync;
    logic                 rxd_prev;
    logic [div_width-1:0] ctr_d, ctr_q;
    logic [2:0]           bit_ctr_d, bit_ctr_q;
    logic [data_bits-1:0] shift_d, shift_q;
    logic                 mid_start;
    logic                 bit_tick;
    logic                 stop_tick;
    rx_entry_t            entry;

    // Half a bit into the start bit, then one full bit between samples
    assign mid_start = (ctr_q == (div >> 1) - 1'b1);
    assign bit_tick  = (ctr_q == div - 1'b1);
    assign stop_tick = (state_q == st_stop) && bit_tick;

    always_comb begin
        entry.data      = shift_q;
        entry.frame_err = ~rxd_sync;
    end

    assign q.wdata   = entry;
    assign q.push    = stop_tick && !q.full;
    assign push_drop = stop_tick && q.full;

    always_comb begin
        state_d   = state_q;
        ctr_d     = ctr_q + 1'b1;
        bit_ctr_d = bit_ctr_q;
        shift_d   = shift_q;
        case (state_q)
            st_idle: begin
                ctr_d     = '0;
                bit_ctr_d = '0;
                if (rxd_prev && !rxd_sync) begin
                    state_d = st_start;
                end
            end
            st_start: begin
                // Line back high at mid-bit means a glitch, not a start bit
                if (mid_start) begin
                    ctr_d   = '0;
                    state_d = rxd_sync ? st_idle : st_data;
                end
            end
            st_data: begin
                if (bit_tick) begin
                    ctr_d   = '0;
                    shift_d = {rxd_sync, shift_q[data_bits-1:1]};
                    if (bit_ctr_q == 3'(data_bits - 1)) begin
                        state_d = st_stop;
                    end else begin
                        bit_ctr_d = bit_ctr_q + 1'b1;
                    end
                end
            end
            st_stop: begin
                if (bit_tick) begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
        if (!rx_en) begin
            state_d = st_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
            state_q  <= st_idle;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
            state_q  <= state_d;
        end
        ctr_q     <= ctr_d;
        bit_ctr_q <= bit_ctr_d;
        shift_q   <= shift_d;
    end

endmodule

// File: rtl/uart_top.sv
module uart_top
    import uart_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        rxd,
    output logic        txd
);

    logic                 tx_en;
    logic                 rx_en;
    logic                 tx_busy;
    logic                 push_drop;
    logic [div_width-1:0] div;

    fifo_if #(.payload_t(logic [data_bits-1:0])) tx_q_if ();
    fifo_if #(.payload_t(rx_entry_t))            rx_q_if ();

    uart_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .tx_wr     (tx_q_if),
        .rx_rd     (rx_q_if),
        .tx_en     (tx_en),
        .rx_en     (rx_en),
        .div       (div),
        .tx_busy   (tx_busy),
        .push_drop (push_drop)
    );

    uart_fifo #(.payload_t(logic [data_bits-1:0]), .depth(fifo_depth)) tx_q (
        .clk (clk),
        .rst (rst),
        .wr  (tx_q_if),
        .rd  (tx_q_if)
    );

    uart_fifo #(.payload_t(rx_entry_t), .depth(fifo_depth)) rx_q (
        .clk (clk),
        .rst (rst),
        .wr  (rx_q_if),
        .rd  (rx_q_if)
    );

    uart_tx u_tx (
        .clk   (clk),
        .rst   (rst),
        .tx_en (tx_en),
        .div   (div),
        .q     (tx_q_if),
        .busy  (tx_busy),
        .txd   (txd)
    );

    uart_rx u_rx (
        .clk       (clk),
        .rst       (rst),
        .rx_en     (rx_en),
        .div       (div),
        .rxd       (rxd),
        .q         (rx_q_if),
        .push_drop (push_drop)
    );

endmodule

// File: tests/tb_clock.sv
module tb_clock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    // 10 ns period
    localparam int half_period = 5;

    initial begin
        clk = 1'b0;
    end

    always #half_period clk = ~clk;

endmodule

// File: tests/uart_props.sv
module uart_props (
    input logic        clk,
    input logic        rst,
    input logic        psel,
    input logic        penable,
    input logic        pready,
    input logic        pslverr,
    input logic [31:0] prdata,
    input logic        txd
);

    timeunit 1ns;
    timeprecision 1ps;

    logic wait_state;

    assign wait_state = psel && penable && !pready;

    // An error response belongs to the completing cycle only
    a_slverr_with_ready: assert property (@(posedge clk) disable iff (rst) pslverr |-> pready)
        else $error("pslverr raised without pready");

    a_txd_idle_in_reset: assert property (@(posedge clk) rst |=> txd)
        else $error("txd left the idle level while in reset");

    a_prdata_stable: assert property (@(posedge clk) disable iff (rst)
        wait_state |-> $stable(prdata))
        else $error("prdata changed while pready was low");

endmodule

bind uart_top uart_props u_props (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .pslverr (pslverr),
    .prdata  (prdata),
    .txd     (txd)
);

// File: tests/tb_uart.sv
module tb_uart
    import uart_regs_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int apb_limit  = 16;
    localparam int poll_limit = 5000;

    logic        clk;
    logic        rst;
    logic [3:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        rxd;
    logic        txd;
    logic        loopback;
    logic        rxd_drive;
    int          cases_run;

    tb_clock u_clock (
        .clk (clk)
    );

    // The serial input either hears the transmitter or carries injected frames
    assign rxd = loopback ? txd : rxd_drive;

    uart_top u_dut (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .rxd     (rxd),
        .txd     (txd)
    );

    // Every word-aligned offset of the 4-bit space holds a register
    function automatic logic is_mapped(input logic [3:0] addr);
        return addr[1:0] == 2'b00;
    endfunction

    task automatic give_up(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            give_up($sformatf("FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual));
        end
    endtask

    task automatic apb_access(input string name, input logic [3:0] addr, input logic write,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int   waited;
        logic err;
        waited = 0;
        @(negedge clk);
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        // The transfer completes at the rising edge that sees pready
        @(posedge clk);
        while (!pready && waited < apb_limit) begin
            waited++;
            @(posedge clk);
        end
        if (!pready) begin
            give_up($sformatf("the DUT never raised pready in case %s", name));
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        compare({name, "_pslverr"}, {31'h0, !is_mapped(addr)}, {31'h0, err});
    endtask

    task automatic poll_reg(input string name, input logic [3:0] addr,
                            input logic [31:0] mask, input logic [31:0] expected);
        logic [31:0] value;
        int          tries;
        tries = 0;
        apb_access(name, addr, 1'b0, '0, value);
        while (((value & mask) != expected) && tries < poll_limit) begin
            tries++;
            apb_access(name, addr, 1'b0, '0, value);
        end
        if ((value & mask) != expected) begin
            give_up($sformatf("register polling timed out in case %s", name));
        end
    endtask

    // Start bit, eight data bits LSB first, stop bit, then one idle bit
    task automatic inject_frame(input int bit_cycles, input logic [7:0] value,
                                input logic stop);
        logic [9:0] bits;
        bits = {stop, value, 1'b0};
        @(negedge clk);
        repeat (10) begin
            rxd_drive = bits[0];
            bits      = bits >> 1;
            repeat (bit_cycles) @(negedge clk);
        end
        rxd_drive = 1'b1;
        repeat (bit_cycles) @(negedge clk);
    endtask

    task automatic watch_idle(input string name, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            compare(name, 32'h1, {31'h0, txd});
        end
    endtask

    task automatic loopback_byte(input string name, input logic [31:0] divisor,
                                 input logic [7:0] byte_in, input logic [31:0] expected);
        logic [31:0] value;
        logic [31:0] ctrl_word;
        ctrl_word = (32'(1) << ctrl_tx_en_bit) | (32'(1) << ctrl_rx_en_bit);
        apb_access(name, addr_div, 1'b1, divisor, value);
        apb_access(name, addr_ctrl, 1'b1, ctrl_word, value);
        apb_access(name, addr_data, 1'b1, {24'h0, byte_in}, value);
        poll_reg(name, addr_status, 32'(1) << status_rx_empty_bit, '0);
        apb_access(name, addr_data, 1'b0, '0, value);
        compare(name, expected, value);
        // The stop bit has to end before the divisor may change
        poll_reg(name, addr_status, 32'(1) << status_tx_busy_bit, '0);
    endtask

    task automatic run_case(input string op, input string name, input logic [31:0] arg,
                            input logic [31:0] data, input logic [31:0] expected);
        logic [31:0] value;
        case (op)
            "wr": apb_access(name, arg[3:0], 1'b1, data, value);
            "rd": begin
                apb_access(name, arg[3:0], 1'b0, '0, value);
                compare(name, expected, value);
            end
            "poll": poll_reg(name, arg[3:0], data, expected);
            "mode": begin
                @(negedge clk);
                rxd_drive = 1'b1;
                loopback  = arg[0];
            end
            "idle": watch_idle(name, int'(arg));
            "frame": inject_frame(int'(arg), data[7:0], expected[0]);
            "loop": loopback_byte(name, arg, data[7:0], expected);
            default: give_up($sformatf("unknown operation %s in case %s", op, name));
        endcase
        cases_run++;
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        string       op;
        string       name;
        logic [31:0] arg;
        logic [31:0] data;
        logic [31:0] expected;
        rst       = 1'b1;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        loopback  = 1'b1;
        rxd_drive = 1'b1;
        cases_run = 0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        fd = $fopen("tests/uart_cases.txt", "r");
        if (fd == 0) begin
            give_up("the cases file tests/uart_cases.txt could not be opened");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %s %h %h %h", op, name, arg, data, expected);
                    if (n == 5) begin
                        run_case(op, name, arg, data, expected);
                    end else if (n > 0) begin
                        give_up($sformatf("malformed line in the cases file: %s", line));
                    end
                end
            end
            $fclose(fd);
        end
        if (cases_run == 0) begin
            give_up("no cases were read from the cases file");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// File: tests/uart_cases.txt
# op name arg data expect, all numbers in hex
# wr/rd/poll: arg is the APB offset, poll uses data as mask; frame/loop: arg is the divisor
rd    reset_status    4    0         16
rd    reset_ctrl      8    0         0
rd    reset_div       c    0         10
wr    div_low         c    2         0
rd    div_clamped     c    0         4
mode  loopback_on     1    0         0
loop  loop_div4       4    55        255
loop  loop_div5       5    a3        2a3
loop  loop_div16      10   0f        20f
loop  loop_div7       7    c8        2c8
wr    hold_div        c    10        0
wr    hold_ctrl       8    2         0
wr    hold_byte       0    5a        0
rd    hold_status     4    0         14
idle  hold_line       140  0         0
wr    hold_release    8    3         0
poll  hold_wait       4    4         0
rd    hold_data       0    0         25a
poll  hold_done       4    1f        6
mode  inject_on       0    0         0
wr    ferr_div        c    8         0
wr    ferr_ctrl       8    2         0
frame ferr_frame      8    a5        0
poll  ferr_wait       4    4         0
rd    ferr_data       0    0         3a5
frame good_frame      8    3c        1
poll  good_wait       4    4         0
rd    good_data       0    0         23c
frame ovr_frame1      8    11        1
frame ovr_frame2      8    22        1
frame ovr_frame3      8    33        1
frame ovr_frame4      8    44        1
frame ovr_frame5      8    55        1
rd    ovr_status      4    0         3a
rd    ovr_data1       0    0         211
rd    ovr_data2       0    0         222
rd    ovr_data3       0    0         233
rd    ovr_data4       0    0         244
rd    ovr_data_none   0    0         0
rd    ovr_sticky      4    0         36
wr    ovr_clear       4    20        0
rd    ovr_cleared     4    0         16
rd    bad_read        2    0         0
wr    bad_write       6    ffffffff  0
rd    bad_ctrl        8    0         2
rd    bad_div         c    0         8
rd    bad_status      4    0         16

// File: verilog.f
rtl/uart_pkg.sv
rtl/uart_regs_pkg.sv
rtl/fifo_if.sv
rtl/uart_fifo.sv
rtl/uart_regs.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_top.sv
tests/tb_clock.sv
tests/uart_props.sv
tests/tb_uart.sv

// File: Makefile
sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_uart \
		-f verilog.f -o sim_uart
	@out="$$(./obj_dir/sim_uart)"; echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean
